/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_card_bus
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
+incdir+tests
verilog/card_bus_pkg.sv
verilog/command_receiver.sv
verilog/card_bus_engine.sv
verilog/reply_formatter.sv
verilog/card_bus_controller.sv
tests/tb_card_bus.sv

/* tests/tb_card_bus_ref.svh */
`ifndef TB_CARD_BUS_REF_SVH
`define TB_CARD_BUS_REF_SVH

// Pins at the first low cycle of the strobe for card k
function automatic bus_pins_t expected_pulse(input int k, input logic [7:0] addr,
                                             input logic [7:0] value);
    bus_pins_t p;
    p                = '0;
    p.card_select[k] = 1'b1;                           // One-hot slot k
    p.address        = addr[2:0];                      // Low 3 address bits
    p.data_out       = value;                          // Data byte k
    p.data_oe        = 1'b1;
    p.wr_n           = 1'b0;
    return p;
endfunction

// Quiet bus, strobe high and drivers off
function automatic bus_pins_t idle_pins();
    bus_pins_t p;
    p      = '0;
    p.wr_n = 1'b1;
    return p;
endfunction

function automatic logic [7:0] hex_char(input logic [3:0] nib);
    logic [7:0] c;
    c = {4'h0, nib};
    return (nib < 4'd10) ? 8'h30 + c : 8'h37 + c;     // '0'..'9', 'A'..'F'
endfunction

// Prefix, two upper-case digits, CR LF
function automatic string reply_text(input string prefix, input logic [7:0] value);
    return $sformatf("%s%c%c%c%c", prefix, hex_char(value[7:4]), hex_char(value[3:0]),
                     8'h0D, 8'h0A);
endfunction

function automatic string read_reply(input logic [7:0] value);
    return reply_text("Read 0x", value);
endfunction

function automatic string fail_reply(input logic [7:0] code);
    return reply_text("Failed 0x", code);
endfunction

task automatic check_pins(input bus_pins_t got, input bus_pins_t exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t: %s pins got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_reply(input string got, input string exp, input string what);
    checks++;
    if (got != exp) begin
        errors++;
        $display("Mismatch at %0t: %s got '%s' expected '%s'", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
        errors++;
        $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

`endif

/* tests/tb_card_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_card_bus
    import card_bus_pkg::*;
();

    localparam int LINE_CYCLES  = 3 * LINE_MAX;        // Line in, reply out, drain
    localparam int WRITE_CYCLES = CARD_COUNT * (10 * WAIT_UNIT_CYCLES + 1) + 1;
    localparam int DRAIN_CYCLES = 20;                  // Quiet time before "nothing" checks
    localparam int FIRST_PULSE_CYCLES = 5 * WAIT_UNIT_CYCLES + 2; // Command to first strobe
    localparam int TEST_CYCLES  = (STARTUP_CYCLES + 2) + (LINE_CYCLES + WRITE_CYCLES)
                                  + 3 * LINE_CYCLES + FIRST_PULSE_CYCLES
                                  + (2 * LINE_CYCLES + WRITE_CYCLES);
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic       clock;
    logic       rst_n;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic [7:0] bus_data_in;
    logic       tx_valid;
    logic [7:0] tx_data;
    bus_pins_t  bus;
    logic       lamp_reset;
    logic       level_shift_en;

    integer     seed = 32'h41c3_c27d;
    int         checks = 0;
    int         errors = 0;
    int         tests = 0;
    int         cycle_count = 0;
    logic [7:0] model_byte;                            // Byte the cards present on reads
    logic [7:0] wr_addr;
    logic [7:0] wr_data [CARD_COUNT];
    bus_pins_t  pulse_pins [$];                        // Snapshot per wr_n fall
    int         pulse_width [$];
    string      replies [$];
    string      tx_text = "";
    logic       wr_prev = 1'b1;
    int         low_run = 0;

    `include "tb_card_bus_ref.svh"

    card_bus_controller dut0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .bus_data_in    (bus_data_in),
        .tx_valid       (tx_valid),
        .tx_data        (tx_data),
        .bus            (bus),
        .lamp_reset     (lamp_reset),
        .level_shift_en (level_shift_en)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Board joins data pins, cards drive when controller is off
    always @(posedge clock) begin
        bus_data_in <= bus.data_oe ? bus.data_out : model_byte;
    end

    always @(posedge clock) begin
        if (!bus.wr_n && wr_prev) begin
            pulse_pins.push_back(bus);                 // Falling edge of strobe
            low_run = 0;
        end
        if (!bus.wr_n) begin
            low_run++;
        end
        if (bus.wr_n && !wr_prev) begin
            pulse_width.push_back(low_run);
        end
        wr_prev = bus.wr_n;
    end

    always @(posedge clock) begin
        if (tx_valid) begin
            tx_text = {tx_text, $sformatf("%c", tx_data)};
            if (tx_data == 8'h0A) begin                // LF closes a reply
                replies.push_back(tx_text);
                tx_text = "";
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One byte per clock, then CR LF
    task automatic send_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            @(posedge clock);
            rx_valid <= 1'b1;
            rx_data  <= text[i];
        end
        @(posedge clock);
        rx_data <= 8'h0D;                              // Receiver skips CR
        @(posedge clock);
        rx_data <= 8'h0A;
        @(posedge clock);
        rx_valid <= 1'b0;
    endtask

    task automatic start_write();
        wr_addr = 8'($random(seed));
        for (int k = 0; k < CARD_COUNT; k++) begin
            wr_data[k] = 8'($random(seed));
        end
        send_line($sformatf("pb_i_write,%02h%02h%02h%02h%02h", wr_addr,
                            wr_data[0], wr_data[1], wr_data[2], wr_data[3]));
    endtask

    task automatic wait_write_done();
        while (pulse_pins.size() < CARD_COUNT) begin
            @(negedge clock);
        end
        while (bus.card_select != '0) begin            // Last card released
            @(negedge clock);
        end
        repeat (DRAIN_CYCLES) @(negedge clock);
    endtask

    task automatic check_write(input string what);
        check_count(pulse_pins.size(), CARD_COUNT, {what, " pulse count"});
        for (int k = 0; k < CARD_COUNT && pulse_pins.size() > 0; k++) begin
            check_pins(pulse_pins.pop_front(), expected_pulse(k, wr_addr, wr_data[k]),
                       $sformatf("%s card %0d", what, k));
            check_count(pulse_width.pop_front(), 2 * WAIT_UNIT_CYCLES,
                        $sformatf("%s card %0d wr_n width", what, k));
        end
    endtask

    task automatic wait_reply(output string line);
        while (replies.size() == 0) begin
            @(negedge clock);
        end
        line = replies.pop_front();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        string line;
        int    hold;
        int    mark;
        rst_n       <= 1'b0;
        rx_valid    <= 1'b0;
        rx_data     <= 8'h00;
        bus_data_in <= 8'h00;
        model_byte  <= 8'h00;
        hold = 0;

        mark = errors;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_flag(lamp_reset, 1'b1, "lamp_reset after reset");
        check_flag(level_shift_en, 1'b0, "level_shift_en after reset");
        check_pins(bus, idle_pins(), "bus after reset");
        while (lamp_reset) begin
            @(negedge clock);
            hold++;
        end
        check_count(hold, STARTUP_CYCLES, "startup hold cycles");
        check_flag(level_shift_en, 1'b1, "level_shift_en after startup");
        finish_test("startup", mark);

        mark = errors;
        start_write();
        wait_write_done();
        check_count(replies.size(), 0, "replies after write");
        check_write("write");
        finish_test("random write", mark);

        mark = errors;
        @(posedge clock);
        model_byte <= 8'($random(seed));
        send_line("pb_i__read,");
        wait_reply(line);
        check_reply(line, read_reply(model_byte), "read reply");
        finish_test("read", mark);

        mark = errors;
        send_line("pb_i_erase,");
        wait_reply(line);
        check_reply(line, fail_reply(8'hAA), "unknown keyword reply");
        finish_test("unknown keyword", mark);

        mark = errors;
        send_line("pb_i_write,0a1b2c3g4d");            // 'g' is not hex
        wait_reply(line);
        check_reply(line, fail_reply(8'hCC), "bad payload reply");
        repeat (FIRST_PULSE_CYCLES + DRAIN_CYCLES) @(negedge clock); // Past any first strobe
        check_count(pulse_pins.size(), 0, "pulses after bad payload");
        finish_test("bad payload", mark);

        mark = errors;
        start_write();
        while (pulse_pins.size() == 0) begin           // Engine is mid write
            @(negedge clock);
        end
        send_line("pb_i__read,");
        wait_reply(line);
        check_reply(line, fail_reply(8'hBB), "busy reply");
        wait_write_done();
        check_count(replies.size(), 0, "replies after busy write");
        check_write("busy write");
        finish_test("busy rejection", mark);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/card_bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module card_bus_controller
    import card_bus_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire        rx_valid,                       // Bytes from the UART receiver
    input  wire  [7:0] rx_data,
    input  wire  [7:0] bus_data_in,                    // Joined to data_out at board level
    output logic       tx_valid,                       // Reply bytes to the UART sender
    output logic [7:0] tx_data,
    output bus_pins_t  bus,
    output logic       lamp_reset,
    output logic       level_shift_en
);

    logic       cmd_valid;
    command_t   cmd;
    logic       err_valid;
    logic [7:0] err_code;
    logic       busy_err_valid;
    logic       read_valid;
    logic [7:0] read_value;

    command_receiver u_receiver (
        .clock     (clock),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .err_valid (err_valid),
        .err_code  (err_code)
    );

    card_bus_engine u_engine (
        .clock          (clock),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .bus_data_in    (bus_data_in),
        .bus            (bus),
        .lamp_reset     (lamp_reset),
        .level_shift_en (level_shift_en),
        .read_valid     (read_valid),
        .read_value     (read_value),
        .busy_err_valid (busy_err_valid)
    );

    reply_formatter u_formatter (
        .clock          (clock),
        .rst_n          (rst_n),
        .err_valid      (err_valid),
        .err_code       (err_code),
        .busy_err_valid (busy_err_valid),
        .read_valid     (read_valid),
        .read_value     (read_value),
        .tx_valid       (tx_valid),
        .tx_data        (tx_data)
    );

endmodule

`default_nettype wire

/* verilog/card_bus_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module card_bus_engine
    import card_bus_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire        cmd_valid,
    input  command_t   cmd,
    input  wire  [7:0] bus_data_in,                    // Pins seen with drivers off
    output bus_pins_t  bus,
    output logic       lamp_reset,
    output logic       level_shift_en,
    output logic       read_valid,
    output logic [7:0] read_value,
    output logic       busy_err_valid
);

    typedef enum logic [2:0] {
        ST_STARTUP,                                    // Lamp reset held
        ST_IDLE,
        ST_SELECT,                                     // Select and address, 4 units
        ST_DATA,                                       // Data driven, 1 unit
        ST_WR_LOW,                                     // Strobe low, 2 units
        ST_WR_HIGH,                                    // Strobe high, 2 units
        ST_RELEASE,                                    // Drivers off, 1 unit
        ST_NEXT                                        // Gap cycle between cards
    } state_t;

    state_t                             state;
    state_t                             next_phase;
    logic [$clog2(STARTUP_CYCLES)-1:0]  startup_cnt;
    logic [$clog2(WAIT_UNIT_CYCLES)-1:0] wait_cnt;     // Cycles within one unit
    logic [2:0]                         unit_cnt;      // Units left in phase
    logic [$clog2(CARD_COUNT)-1:0]      card_idx;
    logic                               unit_done;
    logic                               in_phase;
    command_t                           cmd_q;         // Command being executed

    function automatic logic [2:0] phase_units(input state_t s);
        case (s)
            ST_SELECT:             return 3'd4;
            ST_WR_LOW, ST_WR_HIGH: return 3'd2;
            default:               return 3'd1;        // DATA and RELEASE
        endcase
    endfunction

    always_comb begin
        case (state)
            ST_SELECT:  next_phase = ST_DATA;
            ST_DATA:    next_phase = ST_WR_LOW;
            ST_WR_LOW:  next_phase = ST_WR_HIGH;
            ST_WR_HIGH: next_phase = ST_RELEASE;
            default:    next_phase = ST_NEXT;          // After RELEASE
        endcase
    end

    assign unit_done = (wait_cnt == WAIT_UNIT_CYCLES - 1);
    assign in_phase  = state inside {ST_SELECT, ST_DATA, ST_WR_LOW, ST_WR_HIGH, ST_RELEASE};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_STARTUP;
            startup_cnt    <= '0;
            wait_cnt       <= '0;
            unit_cnt       <= '0;
            card_idx       <= '0;
            read_valid     <= 1'b0;
            busy_err_valid <= 1'b0;
        end else begin
            read_valid     <= 1'b0;
            busy_err_valid <= cmd_valid && (state != ST_IDLE); // Startup counts as busy
            case (state)
                ST_STARTUP: begin
                    if (startup_cnt == STARTUP_CYCLES - 1) begin
                        state <= ST_IDLE;
                    end else begin
                        startup_cnt <= startup_cnt + 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (cmd_valid && cmd.kind == CMD_READ) begin
                        read_valid <= 1'b1;            // Sampled below, same edge
                    end else if (cmd_valid) begin
                        state    <= ST_SELECT;
                        unit_cnt <= phase_units(ST_SELECT);
                        wait_cnt <= '0;
                        card_idx <= '0;
                    end
                end
                ST_NEXT: begin
                    if (card_idx == CARD_COUNT - 1) begin
                        state <= ST_IDLE;              // All cards written
                    end else begin
                        card_idx <= card_idx + 1'b1;
                        state    <= ST_SELECT;
                        unit_cnt <= phase_units(ST_SELECT);
                    end
                end
                default: begin                         // Timed bus phases
                    if (unit_done) begin
                        wait_cnt <= '0;
                        if (unit_cnt == 3'd1) begin
                            state    <= next_phase;
                            unit_cnt <= phase_units(next_phase);
                        end else begin
                            unit_cnt <= unit_cnt - 1'b1;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ST_IDLE && cmd_valid) begin
            cmd_q      <= cmd;
            read_value <= bus_data_in;                 // Drivers already off in idle
        end
    end

    // Pins decoded straight from state
    always_comb begin
        bus             = '0;
        bus.wr_n        = (state != ST_WR_LOW);
        bus.data_oe     = state inside {ST_DATA, ST_WR_LOW, ST_WR_HIGH};
        if (in_phase) begin
            bus.card_select = CARD_COUNT'(1) << card_idx;
            bus.address     = cmd_q.addr[ADDR_WIDTH-1:0];
        end
        if (in_phase && state != ST_SELECT) begin
            bus.data_out = cmd_q.data[card_idx];       // Byte k for card k
        end
    end

    assign lamp_reset     = (state == ST_STARTUP);
    assign level_shift_en = (state != ST_STARTUP);

endmodule

`default_nettype wire

/* verilog/card_bus_pkg.sv */
`default_nettype none

package card_bus_pkg;

    // Sizes
    localparam int LINE_MAX    = 32;                   // Line buffer depth in bytes
    localparam int KEYWORD_LEN = 11;                   // Keyword chars incl. comma
    localparam int PAYLOAD_LEN = 10;                   // Hex chars of a write line
    localparam int CARD_COUNT  = 4;                    // Card slots on the backplane
    localparam int ADDR_WIDTH  = 3;                    // Bus address bits

    // Timing in clock cycles
    localparam int WAIT_UNIT_CYCLES = 22;              // One bus timing unit
    localparam int STARTUP_CYCLES   = 100;             // Lamp reset hold after reset

    // Text
    localparam logic [87:0] KEY_WRITE = "pb_i_write,";
    localparam logic [87:0] KEY_READ  = "pb_i__read,";
    localparam logic [7:0]  CHAR_CR   = 8'h0D;
    localparam logic [7:0]  CHAR_LF   = 8'h0A;
    localparam int          READ_PREFIX_LEN = 7;
    localparam int          FAIL_PREFIX_LEN = 9;
    localparam logic [8*READ_PREFIX_LEN-1:0] READ_PREFIX = "Read 0x";
    localparam logic [8*FAIL_PREFIX_LEN-1:0] FAIL_PREFIX = "Failed 0x";

    // Error codes sent after "Failed 0x"
    localparam logic [7:0] ERR_UNKNOWN = 8'hAA;        // Keyword not recognised
    localparam logic [7:0] ERR_BUSY    = 8'hBB;        // Engine busy or in startup
    localparam logic [7:0] ERR_PAYLOAD = 8'hCC;        // Bad or short hex payload

    typedef enum logic {CMD_WRITE, CMD_READ} cmd_kind_t;

    typedef struct packed {
        cmd_kind_t                      kind;
        logic [7:0]                     addr;          // Low bits go on the bus
        logic [CARD_COUNT-1:0][7:0]     data;          // data[k] is for card k
    } command_t;

    typedef enum logic {REPLY_READ, REPLY_ERROR} reply_kind_t;

    typedef struct packed {
        reply_kind_t kind;
        logic [7:0]  value;                            // Read byte or error code
    } reply_req_t;

    typedef struct packed {
        logic [CARD_COUNT-1:0] card_select;            // One-hot slot select
        logic [ADDR_WIDTH-1:0] address;
        logic [7:0]            data_out;
        logic                  data_oe;                // Drive data pins when high
        logic                  wr_n;                   // Write strobe, active low
    } bus_pins_t;

endpackage

`default_nettype wire

/* verilog/command_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module command_receiver
    import card_bus_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire        rx_valid,                       // One byte per strobe
    input  wire  [7:0] rx_data,
    output logic       cmd_valid,
    output command_t   cmd,
    output logic       err_valid,
    output logic [7:0] err_code
);

    logic [7:0]                   line_buf [LINE_MAX]; // Current line, CR stripped
    logic [$clog2(LINE_MAX):0]    line_len;            // Saturates at LINE_MAX
    logic                         byte_lf;
    logic                         byte_store;
    logic [8*KEYWORD_LEN-1:0]     key_word;
    logic                         is_write;
    logic                         is_read;
    logic [4*PAYLOAD_LEN-1:0]     payload;
    logic [PAYLOAD_LEN-1:0]       hex_ok;
    logic                         payload_ok;
    command_t                     cmd_d;

    // Lower-case hex only, MSB flags a valid char
    function automatic logic [4:0] hex_nibble(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return {1'b1, c[3:0]};
        end
        if (c >= "a" && c <= "f") begin
            return {1'b1, c[3:0] + 4'd9};              // 'a' low nibble is 1
        end
        return 5'b0;
    endfunction

    assign byte_lf    = rx_valid && (rx_data == CHAR_LF);
    assign byte_store = rx_valid && (rx_data != CHAR_LF) && (rx_data != CHAR_CR)
                        && (line_len < LINE_MAX);     // Overflow bytes dropped

    // First bytes packed MSB first, same as string literal
    always_comb begin
        for (int i = 0; i < KEYWORD_LEN; i++) begin
            key_word[8*(KEYWORD_LEN-1-i) +: 8] = line_buf[i];
        end
    end

    assign is_write = (line_len >= KEYWORD_LEN) && (key_word == KEY_WRITE);
    assign is_read  = (line_len >= KEYWORD_LEN) && (key_word == KEY_READ);

    always_comb begin
        for (int i = 0; i < PAYLOAD_LEN; i++) begin
            {hex_ok[i], payload[4*(PAYLOAD_LEN-1-i) +: 4]} =
                hex_nibble(line_buf[KEYWORD_LEN+i]);
        end
    end

    assign payload_ok = (line_len >= KEYWORD_LEN + PAYLOAD_LEN) && (&hex_ok);

    // Address byte first, then data bytes for cards 0..3
    always_comb begin
        cmd_d.kind = is_read ? CMD_READ : CMD_WRITE;
        cmd_d.addr = payload[4*PAYLOAD_LEN-1 -: 8];
        for (int k = 0; k < CARD_COUNT; k++) begin
            cmd_d.data[k] = payload[8*(CARD_COUNT-1-k) +: 8];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            line_len  <= '0;
            cmd_valid <= 1'b0;
            err_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;                         // Single-cycle strobes
            err_valid <= 1'b0;
            if (byte_lf) begin
                line_len <= '0;                        // Start next line
                if (is_read || (is_write && payload_ok)) begin
                    cmd_valid <= 1'b1;
                end else begin
                    err_valid <= 1'b1;
                end
            end else if (byte_store) begin
                line_len <= line_len + 1'b1;
            end
        end
    end

    // Buffer and decoded command hold no reset
    always_ff @(posedge clock) begin
        if (byte_store) begin
            line_buf[line_len[$clog2(LINE_MAX)-1:0]] <= rx_data;
        end
        if (byte_lf) begin
            cmd      <= cmd_d;
            err_code <= is_write ? ERR_PAYLOAD : ERR_UNKNOWN; // Known write, bad hex
        end
    end

endmodule

`default_nettype wire

/* verilog/reply_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_formatter
    import card_bus_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire        err_valid,                      // AA or CC from receiver
    input  wire  [7:0] err_code,
    input  wire        busy_err_valid,                 // BB from engine
    input  wire        read_valid,
    input  wire  [7:0] read_value,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    reply_req_t  req_d;
    reply_req_t  req_q;                                // Reply being sent
    logic        req_valid;
    logic        sending;
    logic [3:0]  idx;                                  // Byte position in frame
    logic [3:0]  prefix_len;
    logic [3:0]  prefix_pos;
    logic [3:0]  last_idx;
    logic [8*FAIL_PREFIX_LEN-1:0] prefix_text;         // Left aligned

    function automatic logic [7:0] hex_upper(input logic [3:0] nib);
        return (nib < 4'd10) ? ("0" + nib) : ("A" + nib - 4'd10);
    endfunction

    assign req_valid   = err_valid || busy_err_valid || read_valid;
    assign req_d.kind  = read_valid ? REPLY_READ : REPLY_ERROR;
    assign req_d.value = read_valid     ? read_value :
                         busy_err_valid ? ERR_BUSY   : err_code;

    always_comb begin
        if (req_q.kind == REPLY_READ) begin
            prefix_len  = 4'(READ_PREFIX_LEN);
            prefix_text = {READ_PREFIX, 16'h0};        // Pad to fail length
        end else begin
            prefix_len  = 4'(FAIL_PREFIX_LEN);
            prefix_text = FAIL_PREFIX;
        end
        last_idx   = prefix_len + 4'd3;                // Two digits, CR, LF
        prefix_pos = (idx < prefix_len) ? idx : 4'd0;  // Keeps select in range
    end

    always_comb begin
        if (idx < prefix_len) begin
            tx_data = prefix_text[8*FAIL_PREFIX_LEN-1 - 8*prefix_pos -: 8];
        end else begin
            case (idx - prefix_len)
                4'd0:    tx_data = hex_upper(req_q.value[7:4]);
                4'd1:    tx_data = hex_upper(req_q.value[3:0]);
                4'd2:    tx_data = CHAR_CR;
                default: tx_data = CHAR_LF;
            endcase
        end
    end

    assign tx_valid = sending;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sending <= 1'b0;
            idx     <= '0;
        end else if (!sending) begin
            if (req_valid) begin
                sending <= 1'b1;
                idx     <= '0;
            end
        end else if (idx == last_idx) begin
            sending <= 1'b0;                           // Frame done
        end else begin
            idx <= idx + 1'b1;
        end
    end

    // Requests while busy sending are dropped
    always_ff @(posedge clock) begin
        if (!sending && req_valid) begin
            req_q <= req_d;
        end
    end

endmodule

`default_nettype wire
